// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/csr_pkg.sv
      - rtl/seq_pkg.sv
      - rtl/machine_timer.sv
      - rtl/csr_file.sv
      - rtl/csr_sequencer.sv
      - rtl/csr_unit_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/csr_unit_tb.sv

// ==== csr_unit_top.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/seq_pkg.sv
rtl/machine_timer.sv
rtl/csr_file.sv
rtl/csr_sequencer.sv
rtl/csr_unit_top.sv
testbench/csr_unit_tb.sv

// ==== rtl/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// parallel data width, also the timer width and pass length.
`define CSR_XLEN 32

// serial bit counter, counts 0 to CSR_XLEN-1.
`define CSR_CNT_W 5

// machine mode CSR addresses.
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343

// only these bits exist in mstatus and mie.
`define CSR_MSTATUS_MIE_BIT 3
`define CSR_MIE_MTIE_BIT    7

`endif

// ==== rtl/csr_file.sv ====
`include "csr_defs.svh"

module csr_file (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_en,
   input  logic [`CSR_CNT_W-1:0] i_cnt,
   input  logic                  i_mtip,
   input  csr_pkg::csr_sel_e     i_csr_sel,
   input  csr_pkg::csr_src_e     i_csr_source,
   input  logic                  i_trap,
   input  logic                  i_pc,
   input  logic                  i_mtval,
   input  logic [3:0]            i_mcause,
   input  logic                  i_d,
   output logic                  o_timer_irq_en,
   output logic                  o_q
);
   import csr_pkg::*;

   logic mstatus_mie;
   logic mie_mtie;
   logic mstatus_q; // MIE presented at count 3, zero elsewhere.
   logic mie_q;     // MTIE presented at count 7.
   logic [`CSR_XLEN-1:0] mtvec;
   logic [`CSR_XLEN-1:0] mscratch;
   logic [`CSR_XLEN-1:0] mepc;
   logic [`CSR_XLEN-1:0] mcause;
   logic [`CSR_XLEN-1:0] mtval;
   logic csr_in;
   logic csr_out;
   logic irq_taken;
   logic mtvec_en;
   logic mscratch_en;
   logic mepc_en;
   logic mcause_en;
   logic mtval_en;

   assign mtvec_en    = i_en & (i_csr_sel == SEL_MTVEC);
   assign mscratch_en = i_en & (i_csr_sel == SEL_MSCRATCH);
   assign mepc_en     = i_en & (i_trap | (i_csr_sel == SEL_MEPC));
   assign mcause_en   = i_en & (i_csr_sel == SEL_MCAUSE);
   assign mtval_en    = i_en & (i_trap | (i_csr_sel == SEL_MTVAL));

   always_comb begin
      case (i_csr_sel)
         SEL_MSTATUS:  csr_out = mstatus_q;
         SEL_MIE:      csr_out = mie_q;
         SEL_MTVEC:    csr_out = mtvec[0];
         SEL_MSCRATCH: csr_out = mscratch[0];
         SEL_MEPC:     csr_out = mepc[0];
         SEL_MCAUSE:   csr_out = mcause[0];
         SEL_MTVAL:    csr_out = mtval[0];
         default:      csr_out = 1'b0;
      endcase
   end

   always_comb begin
      case (i_csr_source)
         SRC_EXT: csr_in = i_d;
         SRC_SET: csr_in = csr_out | i_d;
         SRC_CLR: csr_in = csr_out & ~i_d;
         default: csr_in = csr_out;
      endcase
   end

   assign o_q            = csr_out;
   assign o_timer_irq_en = mstatus_mie & mie_mtie;
   assign irq_taken      = i_mtip & o_timer_irq_en;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mstatus_mie <= 1'b0;
         mie_mtie    <= 1'b0;
         mstatus_q   <= 1'b0;
         mie_q       <= 1'b0;
         mtvec       <= '0;
         mscratch    <= '0;
         mepc        <= '0;
         mcause      <= '0;
         mtval       <= '0;
      end else begin
         if (i_en & (i_cnt == `CSR_MSTATUS_MIE_BIT) & (i_csr_sel == SEL_MSTATUS))
            mstatus_mie <= csr_in;
         if (i_en & (i_cnt == `CSR_MIE_MTIE_BIT) & (i_csr_sel == SEL_MIE))
            mie_mtie <= csr_in;

         // staged one count early so the bit lines up with its position.
         mstatus_q <= i_en & (i_cnt == `CSR_MSTATUS_MIE_BIT - 1) & mstatus_mie;
         mie_q     <= i_en & (i_cnt == `CSR_MIE_MTIE_BIT - 1) & mie_mtie;

         if (mtvec_en)
            mtvec <= {csr_in, mtvec[`CSR_XLEN-1:1]};
         if (mscratch_en)
            mscratch <= {csr_in, mscratch[`CSR_XLEN-1:1]};
         if (mepc_en)
            mepc <= {i_trap ? i_pc : csr_in, mepc[`CSR_XLEN-1:1]};
         if (mtval_en)
            mtval <= {i_trap ? i_mtval : csr_in, mtval[`CSR_XLEN-1:1]};

         if (i_trap) begin
            mcause[`CSR_XLEN-1] <= irq_taken; // interrupt flag.
            mcause[3:0]         <= irq_taken ? CAUSE_MTI : i_mcause;
         end else if (mcause_en) begin
            mcause <= {csr_in, mcause[`CSR_XLEN-1:1]};
         end
      end
   end

endmodule

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

   // register select into the CSR file.
   typedef enum logic [2:0] {
      SEL_MSTATUS  = 3'd0,
      SEL_MIE      = 3'd1,
      SEL_MTVEC    = 3'd2,
      SEL_MSCRATCH = 3'd3,
      SEL_MEPC     = 3'd4,
      SEL_MCAUSE   = 3'd5,
      SEL_MTVAL    = 3'd6
   } csr_sel_e;

   // where the new serial bit comes from.
   typedef enum logic [1:0] {
      SRC_CSR = 2'd0, // keep old bit, read only.
      SRC_EXT = 2'd1, // write input bit.
      SRC_SET = 2'd2, // old | in.
      SRC_CLR = 2'd3  // old & ~in.
   } csr_src_e;

   // cause code used for a pending machine timer interrupt.
   localparam logic [3:0] CAUSE_MTI = 4'd7;

endpackage

// ==== rtl/csr_sequencer.sv ====
`include "csr_defs.svh"

module csr_sequencer (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_req,
   input  seq_pkg::req_kind_e     i_kind,
   input  logic [11:0]            i_addr,
   input  csr_pkg::csr_src_e      i_op,
   input  logic [`CSR_XLEN-1:0]   i_wdata,
   input  logic [`CSR_XLEN-1:0]   i_pc,
   input  logic [`CSR_XLEN-1:0]   i_mtval,
   input  logic [3:0]             i_mcause,
   input  logic                   i_q,
   output logic                   o_busy,
   output logic                   o_done,
   output logic                   o_err,
   output logic [`CSR_XLEN-1:0]   o_rdata,
   output logic                   o_en,
   output logic [`CSR_CNT_W-1:0]  o_cnt,
   output csr_pkg::csr_sel_e      o_sel,
   output csr_pkg::csr_src_e      o_src,
   output logic                   o_trap,
   output logic                   o_d,
   output logic                   o_pc_bit,
   output logic                   o_mtval_bit,
   output logic [3:0]             o_mcause
);
   import csr_pkg::*;
   import seq_pkg::*;

   localparam int unsigned LAST_CNT = `CSR_XLEN - 1;

   seq_state_e state;
   logic [`CSR_CNT_W-1:0] cnt;
   csr_sel_e sel;
   csr_src_e src;
   logic trap;
   logic err;
   logic accept;
   logic addr_ok;
   csr_sel_e dec_sel;
   logic [`CSR_XLEN-1:0] wdata_sr;
   logic [`CSR_XLEN-1:0] pc_sr;
   logic [`CSR_XLEN-1:0] mtval_sr;
   logic [`CSR_XLEN-1:0] rdata;
   logic [3:0] mcause_q;

   always_comb begin
      addr_ok = 1'b1;
      dec_sel = SEL_MSTATUS;
      case (i_addr)
         `CSR_ADDR_MSTATUS:  dec_sel = SEL_MSTATUS;
         `CSR_ADDR_MIE:      dec_sel = SEL_MIE;
         `CSR_ADDR_MTVEC:    dec_sel = SEL_MTVEC;
         `CSR_ADDR_MSCRATCH: dec_sel = SEL_MSCRATCH;
         `CSR_ADDR_MEPC:     dec_sel = SEL_MEPC;
         `CSR_ADDR_MCAUSE:   dec_sel = SEL_MCAUSE;
         `CSR_ADDR_MTVAL:    dec_sel = SEL_MTVAL;
         default:            addr_ok = 1'b0;
      endcase
   end

   assign o_busy = (state == ST_SHIFT);
   assign accept = i_req & ~o_busy; // requests during a pass are dropped.

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
         sel   <= SEL_MSTATUS;
         src   <= SRC_CSR;
         trap  <= 1'b0;
         err   <= 1'b0;
      end else begin
         err <= 1'b0;
         case (state)
            ST_SHIFT: begin
               cnt <= cnt + 1'b1;
               if (cnt == LAST_CNT[`CSR_CNT_W-1:0]) begin
                  state <= ST_DONE;
                  trap  <= 1'b0;
               end
            end
            default: begin
               state <= ST_IDLE;
               if (accept) begin
                  cnt <= '0;
                  if (i_kind == REQ_TRAP) begin
                     // mtvec rotates onto itself and is read out as target.
                     state <= ST_SHIFT;
                     sel   <= SEL_MTVEC;
                     src   <= SRC_CSR;
                     trap  <= 1'b1;
                  end else if (addr_ok) begin
                     state <= ST_SHIFT;
                     sel   <= dec_sel;
                     src   <= i_op;
                  end else begin
                     err <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // operand and result shift registers, lsb first.
   always_ff @(posedge i_clk) begin
      if (accept) begin
         wdata_sr <= i_wdata;
         pc_sr    <= i_pc;
         mtval_sr <= i_mtval;
         mcause_q <= i_mcause;
      end else if (o_busy) begin
         wdata_sr <= wdata_sr >> 1;
         pc_sr    <= pc_sr >> 1;
         mtval_sr <= mtval_sr >> 1;
         rdata    <= {i_q, rdata[`CSR_XLEN-1:1]};
      end
   end

   assign o_done      = (state == ST_DONE);
   assign o_err       = err;
   assign o_rdata     = rdata;
   assign o_en        = o_busy;
   assign o_cnt       = cnt;
   assign o_sel       = sel;
   assign o_src       = src;
   assign o_trap      = trap;
   assign o_d         = wdata_sr[0];
   assign o_pc_bit    = pc_sr[0];
   assign o_mtval_bit = mtval_sr[0];
   assign o_mcause    = mcause_q;

endmodule

// ==== rtl/csr_unit_top.sv ====
`include "csr_defs.svh"

module csr_unit_top (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_req,
   input  seq_pkg::req_kind_e   i_kind,
   input  logic [11:0]          i_addr,
   input  csr_pkg::csr_src_e    i_op,
   input  logic [`CSR_XLEN-1:0] i_wdata,
   input  logic [`CSR_XLEN-1:0] i_pc,
   input  logic [`CSR_XLEN-1:0] i_mtval,
   input  logic [3:0]           i_mcause,
   input  logic                 i_cmp_we,
   input  logic [`CSR_XLEN-1:0] i_cmp_value,
   output logic                 o_busy,
   output logic                 o_done,
   output logic                 o_err,
   output logic [`CSR_XLEN-1:0] o_rdata,
   output logic                 o_timer_irq
);
   import csr_pkg::*;

   logic                  en;
   logic [`CSR_CNT_W-1:0] cnt;
   csr_sel_e              sel;
   csr_src_e              src;
   logic                  trap;
   logic                  d_bit;
   logic                  q_bit;
   logic                  pc_bit;
   logic                  mtval_bit;
   logic [3:0]            mcause;
   logic                  mtip;
   logic                  irq_en;

   csr_sequencer seq_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(i_req), .i_kind(i_kind),
      .i_addr(i_addr), .i_op(i_op), .i_wdata(i_wdata), .i_pc(i_pc),
      .i_mtval(i_mtval), .i_mcause(i_mcause), .i_q(q_bit),
      .o_busy(o_busy), .o_done(o_done), .o_err(o_err), .o_rdata(o_rdata),
      .o_en(en), .o_cnt(cnt), .o_sel(sel), .o_src(src), .o_trap(trap),
      .o_d(d_bit), .o_pc_bit(pc_bit), .o_mtval_bit(mtval_bit), .o_mcause(mcause)
   );

   csr_file csr_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en(en), .i_cnt(cnt), .i_mtip(mtip),
      .i_csr_sel(sel), .i_csr_source(src), .i_trap(trap), .i_pc(pc_bit),
      .i_mtval(mtval_bit), .i_mcause(mcause), .i_d(d_bit),
      .o_timer_irq_en(irq_en), .o_q(q_bit)
   );

   machine_timer timer_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cmp_we(i_cmp_we),
      .i_cmp_value(i_cmp_value), .o_mtip(mtip)
   );

   assign o_timer_irq = mtip & irq_en;

endmodule

// ==== rtl/machine_timer.sv ====
`include "csr_defs.svh"

module machine_timer (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_cmp_we,
   input  logic [`CSR_XLEN-1:0] i_cmp_value,
   output logic                 o_mtip
);

   logic [`CSR_XLEN-1:0] mtime;
   logic [`CSR_XLEN-1:0] mtimecmp;
   logic                 mtip;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime    <= '0;
         mtimecmp <= '1; // far in the future.
         mtip     <= 1'b0;
      end else begin
         mtime <= mtime + 1'b1;
         if (i_cmp_we)
            mtimecmp <= i_cmp_value;
         mtip <= (mtime >= mtimecmp); // unsigned compare.
      end
   end

   assign o_mtip = mtip;

endmodule

// ==== rtl/seq_pkg.sv ====
package seq_pkg;

   // kind of host request.
   typedef enum logic {
      REQ_CSR  = 1'b0,
      REQ_TRAP = 1'b1
   } req_kind_e;

   // sequencer FSM.
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_SHIFT = 2'd1, // one bit per cycle.
      ST_DONE  = 2'd2
   } seq_state_e;

endpackage

// ==== testbench/csr_unit_tb.sv ====
`include "csr_defs.svh"

module csr_unit_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import csr_pkg::*;
   import seq_pkg::*;

   localparam int TIMEOUT = 100;

   logic i_clk, i_rst_n, i_req, i_cmp_we;
   req_kind_e i_kind;
   logic [11:0] i_addr;
   csr_src_e i_op;
   logic [`CSR_XLEN-1:0] i_wdata, i_pc, i_mtval, i_cmp_value;
   logic [3:0] i_mcause;
   logic o_busy, o_done, o_err, o_timer_irq;
   logic [`CSR_XLEN-1:0] o_rdata;

   // reference model state.
   logic m_mie, m_mtie;
   logic [`CSR_XLEN-1:0] m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
   logic [`CSR_XLEN-1:0] m_mtime = '0;
   int n_pass = 0;
   int n_fail = 0;
   int fails_at_start = 0;
   logic [11:0] all_addr [7] = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
      `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL};

   csr_unit_top dut_i (.*);

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      if (i_rst_n)
         m_mtime <= m_mtime + 1'b1; // counts from reset release.
   end

   function automatic logic [`CSR_XLEN-1:0] apply_op(csr_src_e op,
         logic [`CSR_XLEN-1:0] old_v, logic [`CSR_XLEN-1:0] in_v);
      case (op)
         SRC_EXT: return in_v;
         SRC_SET: return old_v | in_v;
         SRC_CLR: return old_v & ~in_v;
         default: return old_v;
      endcase
   endfunction

   function automatic logic [`CSR_XLEN-1:0] model_read(logic [11:0] a);
      case (a)
         `CSR_ADDR_MSTATUS:  return `CSR_XLEN'(m_mie) << `CSR_MSTATUS_MIE_BIT;
         `CSR_ADDR_MIE:      return `CSR_XLEN'(m_mtie) << `CSR_MIE_MTIE_BIT;
         `CSR_ADDR_MTVEC:    return m_mtvec;
         `CSR_ADDR_MSCRATCH: return m_mscratch;
         `CSR_ADDR_MEPC:     return m_mepc;
         `CSR_ADDR_MCAUSE:   return m_mcause;
         default:            return m_mtval;
      endcase
   endfunction

   function automatic void model_write(logic [11:0] a, logic [`CSR_XLEN-1:0] v);
      case (a)
         `CSR_ADDR_MSTATUS:  m_mie = v[`CSR_MSTATUS_MIE_BIT];
         `CSR_ADDR_MIE:      m_mtie = v[`CSR_MIE_MTIE_BIT];
         `CSR_ADDR_MTVEC:    m_mtvec = v;
         `CSR_ADDR_MSCRATCH: m_mscratch = v;
         `CSR_ADDR_MEPC:     m_mepc = v;
         `CSR_ADDR_MCAUSE:   m_mcause = v;
         default:            m_mtval = v;
      endcase
   endfunction

   task automatic check_word(logic [`CSR_XLEN-1:0] got, logic [`CSR_XLEN-1:0] exp, string what);
      if (got === exp) begin
         n_pass++;
      end else begin
         n_fail++;
         $display("CHECK FAILED @%0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got === exp) begin
         n_pass++;
      end else begin
         n_fail++;
         $display("CHECK FAILED @%0t: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic end_test(string name);
      $display("%-22s %s, %0d errors", name, (n_fail == fails_at_start) ? "ok" : "failed",
               n_fail - fails_at_start);
      fails_at_start = n_fail;
   endtask

   // fields stay put until the next request.
   task automatic send_req(req_kind_e k, logic [11:0] a, csr_src_e op,
         logic [`CSR_XLEN-1:0] wd, logic [`CSR_XLEN-1:0] p, logic [`CSR_XLEN-1:0] tv,
         logic [3:0] c);
      @(posedge i_clk);
      i_req <= 1'b1;
      i_kind <= k;
      i_addr <= a;
      i_op <= op;
      i_wdata <= wd;
      i_pc <= p;
      i_mtval <= tv;
      i_mcause <= c;
      @(posedge i_clk);
      i_req <= 1'b0;
   endtask

   task automatic wait_done(output logic [`CSR_XLEN-1:0] rd);
      seq_state_e st;
      logic seen;
      logic busy_held;
      seen = 1'b0;
      busy_held = 1'b1;
      rd = 'x;
      for (int i = 0; i < TIMEOUT && !seen; i++) begin
         @(negedge i_clk);
         seen = o_done;
         if (!seen)
            busy_held &= o_busy;
      end
      if (seen) begin
         rd = o_rdata;
         check_flag(busy_held, 1'b1, "busy low during a pass");
         check_flag(o_busy, 1'b0, "busy together with done");
      end else begin
         st = dut_i.seq_i.state;
         n_fail++;
         $display("Timed out after %0d cycles waiting for done, sequencer in %s.",
                  TIMEOUT, st.name());
      end
   endtask

   task automatic read_check(logic [11:0] a);
      logic [`CSR_XLEN-1:0] rd;
      send_req(REQ_CSR, a, SRC_CSR, $urandom, $urandom, $urandom, 4'(0));
      wait_done(rd);
      check_word(rd, model_read(a), $sformatf("read of csr %h", a));
   endtask

   task automatic access_check(logic [11:0] a, csr_src_e op, logic [`CSR_XLEN-1:0] wd);
      logic [`CSR_XLEN-1:0] rd;
      logic [`CSR_XLEN-1:0] old_v;
      old_v = model_read(a);
      send_req(REQ_CSR, a, op, wd, $urandom, $urandom, 4'(0));
      wait_done(rd);
      check_word(rd, old_v, $sformatf("old value of csr %h, op %s", a, op.name()));
      model_write(a, apply_op(op, old_v, wd));
      read_check(a);
   endtask

   task automatic trap_check(logic pending);
      logic [`CSR_XLEN-1:0] rd, p, tv;
      logic [3:0] c;
      p = $urandom;
      tv = $urandom;
      c = 4'($urandom_range(0, 15));
      send_req(REQ_TRAP, 12'($urandom), csr_src_e'($urandom_range(0, 3)), $urandom, p, tv, c);
      wait_done(rd);
      check_word(rd, m_mtvec, "trap target from mtvec");
      m_mepc = p;
      m_mtval = tv;
      m_mcause = {pending, m_mcause[`CSR_XLEN-2:4], pending ? 4'd7 : c};
      read_check(`CSR_ADDR_MEPC);
      read_check(`CSR_ADDR_MTVAL);
      read_check(`CSR_ADDR_MCAUSE);
   endtask

   task automatic illegal_check();
      logic [11:0] a;
      logic saw_err, saw_done;
      do a = 12'($urandom); while (a inside {all_addr});
      send_req(REQ_CSR, a, csr_src_e'($urandom_range(0, 3)), $urandom, $urandom, $urandom, 4'(0));
      saw_err = 1'b0;
      saw_done = 1'b0;
      for (int i = 0; i < TIMEOUT && !saw_err; i++) begin
         @(negedge i_clk);
         saw_err = o_err;
         saw_done |= o_done;
      end
      if (!saw_err) begin
         n_fail++;
         $display("No error pulse within %0d cycles for address %h.", TIMEOUT, a);
      end
      check_flag(saw_done, 1'b0, $sformatf("done pulse for unknown address %h", a));
      @(negedge i_clk);
      check_flag(o_err, 1'b0, "error pulse longer than one cycle");
      check_flag(o_busy, 1'b0, "busy after unknown address");
   endtask

   initial begin
      logic [`CSR_XLEN-1:0] cmp;
      logic seen;
      void'($urandom(32'h12c5d5f3));
      i_rst_n = 1'b0;
      i_req = 1'b0;
      i_kind = REQ_CSR;
      i_addr = '0;
      i_op = SRC_CSR;
      i_wdata = '0;
      i_pc = '0;
      i_mtval = '0;
      i_mcause = '0;
      i_cmp_we = 1'b0;
      i_cmp_value = '0;
      {m_mie, m_mtie} = 2'b00;
      {m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
      repeat (10) @(posedge i_clk);
      i_rst_n <= 1'b1;
      @(negedge i_clk);
      check_flag(o_busy | o_done | o_err | o_timer_irq, 1'b0, "outputs after reset");

      repeat (40) access_check(all_addr[$urandom_range(2, 6)],
                               csr_src_e'($urandom_range(0, 3)), $urandom);
      end_test("test 1 word csrs");
      repeat (20) access_check(all_addr[$urandom_range(0, 1)],
                               csr_src_e'($urandom_range(0, 3)), $urandom);
      end_test("test 2 mstatus and mie");
      repeat (10) illegal_check();
      foreach (all_addr[i]) read_check(all_addr[i]); // nothing may have changed.
      end_test("test 3 unknown address");
      access_check(`CSR_ADDR_MTVEC, SRC_EXT, $urandom);
      access_check(`CSR_ADDR_MSTATUS, SRC_CLR, `CSR_XLEN'(1) << `CSR_MSTATUS_MIE_BIT);
      repeat (10) trap_check(1'b0); // mtimecmp still at reset value.
      end_test("test 4 trap entry");

      access_check(`CSR_ADDR_MSTATUS, SRC_SET, `CSR_XLEN'(1) << `CSR_MSTATUS_MIE_BIT);
      access_check(`CSR_ADDR_MIE, SRC_SET, `CSR_XLEN'(1) << `CSR_MIE_MTIE_BIT);
      cmp = m_mtime + 20 + $urandom_range(0, 40);
      @(posedge i_clk);
      i_cmp_we <= 1'b1;
      i_cmp_value <= cmp;
      @(posedge i_clk);
      i_cmp_we <= 1'b0;
      // pending shows one cycle after mtime reaches the compare value.
      for (int i = 0; i < TIMEOUT; i++) begin
         @(negedge i_clk);
         if (m_mtime > cmp)
            break;
         check_flag(o_timer_irq, 1'b0, "timer irq before compare");
      end
      seen = o_timer_irq;
      for (int i = 0; i < TIMEOUT && !seen; i++) begin
         @(negedge i_clk);
         seen = o_timer_irq;
      end
      if (!seen) begin
         n_fail++;
         $display("Timer interrupt did not rise within %0d cycles of mtimecmp.", TIMEOUT);
      end
      trap_check(1'b1);
      check_flag(o_timer_irq, 1'b1, "timer irq held after trap");
      end_test("test 5 timer interrupt");

      $display("checks passed %0d, checks failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
